//--- compile.f
design/decodePkg.sv
design/decodeIf.sv
design/controlDecoder.sv
design/registerFile.sv
design/decodeToExecute.sv
design/decodeStage.sv
verif/clockGen.sv
verif/decodeStage_chk.sv
verif/decodeStageMon.sv
verif/decodeStageTb.sv

//--- design/controlDecoder.sv
`timescale 1ns/1ns
`default_nettype none

module controlDecoder #(
        parameter int DataWidth    = decodePkg::DataWidth,
        parameter int RegAddrWidth = decodePkg::RegAddrWidth
) (
        input  wire [DataWidth-1:0]     Instr,
        ctrlIf.src                      Ctrl,
        output logic [RegAddrWidth-1:0] Rs
);

        logic [decodePkg::OpWidth-1:0]  opcode;
        logic [decodePkg::OpWidth-1:0]  funct;
        logic [decodePkg::ImmWidth-1:0] imm;
        logic [DataWidth-1:0]           signExt;
        logic [DataWidth-1:0]           zeroExt;
        logic [DataWidth-1:0]           shamt;
        decodePkg::memSizeT             memSize;

        ////////////////////
        // Field split
        ////////////////////

        assign opcode = Instr[31:26];
        assign Rs     = Instr[25:21];
        assign funct  = Instr[5:0];
        assign imm    = Instr[15:0];

        assign signExt = {{(DataWidth - decodePkg::ImmWidth){imm[decodePkg::ImmWidth-1]}}, imm};
        assign zeroExt = {{(DataWidth - decodePkg::ImmWidth){1'b0}}, imm};
        assign shamt   = {{(DataWidth - 5){1'b0}}, Instr[10:6]};

        // Low opcode bits give the access size, loads and stores alike
        assign memSize = opcode[1] ? decodePkg::memWord :
                         opcode[0] ? decodePkg::memHalf : decodePkg::memByte;

        ////////////////////
        // Control set
        ////////////////////

        always_comb begin
                // Bubble unless a legal encoding matches
                Ctrl.RegWrite   = 1'b0;
                Ctrl.AluSrc     = 1'b0;
                Ctrl.RegDst     = 1'b0;
                Ctrl.MemToReg   = 1'b0;
                Ctrl.Jr         = 1'b0;
                Ctrl.Jal        = 1'b0;
                Ctrl.MemWrite   = decodePkg::memNone;
                Ctrl.MemRead    = decodePkg::memNone;
                Ctrl.AluControl = decodePkg::aluNop;
                Ctrl.Imm        = signExt;

                case (opcode)
                        decodePkg::opSpecial: begin
                                Ctrl.RegWrite = 1'b1;
                                Ctrl.RegDst   = 1'b1;
                                case (funct)
                                        decodePkg::fnAdd: Ctrl.AluControl = decodePkg::aluAdd;
                                        decodePkg::fnSub: Ctrl.AluControl = decodePkg::aluSub;
                                        decodePkg::fnAnd: Ctrl.AluControl = decodePkg::aluAnd;
                                        decodePkg::fnOr:  Ctrl.AluControl = decodePkg::aluOr;
                                        decodePkg::fnNor: Ctrl.AluControl = decodePkg::aluNor;
                                        decodePkg::fnSlt: Ctrl.AluControl = decodePkg::aluSlt;
                                        decodePkg::fnSll: begin
                                                Ctrl.AluControl = decodePkg::aluSll;
                                                Ctrl.Imm        = shamt;
                                        end
                                        decodePkg::fnSrl: begin
                                                Ctrl.AluControl = decodePkg::aluSrl;
                                                Ctrl.Imm        = shamt;
                                        end
                                        // jr writes nothing back
                                        decodePkg::fnJr: begin
                                                Ctrl.RegWrite = 1'b0;
                                                Ctrl.RegDst   = 1'b0;
                                                Ctrl.Jr       = 1'b1;
                                        end
                                        default: begin
                                                Ctrl.RegWrite = 1'b0;
                                                Ctrl.RegDst   = 1'b0;
                                        end
                                endcase
                        end
                        decodePkg::opAddi, decodePkg::opSlti: begin
                                Ctrl.RegWrite   = 1'b1;
                                Ctrl.AluSrc     = 1'b1;
                                Ctrl.AluControl = opcode[1] ? decodePkg::aluSlt
                                                            : decodePkg::aluAdd;
                        end
                        decodePkg::opAndi, decodePkg::opOri: begin
                                Ctrl.RegWrite   = 1'b1;
                                Ctrl.AluSrc     = 1'b1;
                                Ctrl.Imm        = zeroExt;
                                Ctrl.AluControl = opcode[0] ? decodePkg::aluOr
                                                            : decodePkg::aluAnd;
                        end
                        decodePkg::opLw, decodePkg::opLh, decodePkg::opLb: begin
                                Ctrl.RegWrite   = 1'b1;
                                Ctrl.AluSrc     = 1'b1;
                                Ctrl.MemToReg   = 1'b1;
                                Ctrl.MemRead    = memSize;
                                Ctrl.AluControl = decodePkg::aluAdd;
                        end
                        decodePkg::opSw, decodePkg::opSh, decodePkg::opSb: begin
                                Ctrl.AluSrc     = 1'b1;
                                Ctrl.MemWrite   = memSize;
                                Ctrl.AluControl = decodePkg::aluAdd;
                        end
                        // Link register write, target computed elsewhere
                        decodePkg::opJal: begin
                                Ctrl.RegWrite = 1'b1;
                                Ctrl.Jal      = 1'b1;
                        end
                        default: begin
                        end
                endcase
        end

endmodule

`default_nettype wire

//--- design/decodeIf.sv
`timescale 1ns/1ns
`default_nettype none

// Decoder results headed for the decode-to-execute register
interface ctrlIf #(
        parameter int DataWidth = decodePkg::DataWidth
);
        logic                 RegWrite;
        logic                 AluSrc;
        logic                 RegDst;
        logic                 MemToReg;
        logic                 Jr;
        logic                 Jal;
        decodePkg::memSizeT   MemWrite;
        decodePkg::memSizeT   MemRead;
        decodePkg::aluOpT     AluControl;
        logic [DataWidth-1:0] Imm;

        modport src (output RegWrite, AluSrc, RegDst, MemToReg, Jr, Jal,
                     MemWrite, MemRead, AluControl, Imm);
        modport dst (input RegWrite, AluSrc, RegDst, MemToReg, Jr, Jal,
                     MemWrite, MemRead, AluControl, Imm);
endinterface

// Register operands plus the two candidate destinations
interface operandIf #(
        parameter int DataWidth    = decodePkg::DataWidth,
        parameter int RegAddrWidth = decodePkg::RegAddrWidth
);
        logic [DataWidth-1:0]    ReadData1;
        logic [DataWidth-1:0]    ReadData2;
        logic [RegAddrWidth-1:0] Rt;
        logic [RegAddrWidth-1:0] Rd;

        modport src (output ReadData1, ReadData2, Rt, Rd);
        modport dst (input ReadData1, ReadData2, Rt, Rd);
endinterface

`default_nettype wire

//--- design/decodePkg.sv
`default_nettype none

package decodePkg;

        // Datapath widths
        localparam int DataWidth    = 32;
        localparam int RegAddrWidth = 5;

        // Opcode and function fields are both 6 bits wide
        localparam int OpWidth      = 6;
        localparam int ImmWidth     = 16;

        ////////////////////
        // Instruction encodings
        ////////////////////

        typedef enum logic [OpWidth-1:0] {
                opSpecial = 6'h00,
                opJal     = 6'h03,
                opAddi    = 6'h08,
                opSlti    = 6'h0a,
                opAndi    = 6'h0c,
                opOri     = 6'h0d,
                opLb      = 6'h20,
                opLh      = 6'h21,
                opLw      = 6'h23,
                opSb      = 6'h28,
                opSh      = 6'h29,
                opSw      = 6'h2b
        } opcodeT;

        // R-type function codes
        typedef enum logic [OpWidth-1:0] {
                fnSll = 6'h00,
                fnSrl = 6'h02,
                fnJr  = 6'h08,
                fnAdd = 6'h20,
                fnSub = 6'h22,
                fnAnd = 6'h24,
                fnOr  = 6'h25,
                fnNor = 6'h27,
                fnSlt = 6'h2a
        } functT;

        ////////////////////
        // Execute-side codes
        ////////////////////

        // Zero is the bubble, so a cleared register reads as a nop
        typedef enum logic [4:0] {
                aluNop = 5'd0,
                aluAdd = 5'd1,
                aluSub = 5'd2,
                aluAnd = 5'd3,
                aluOr  = 5'd4,
                aluNor = 5'd5,
                aluSlt = 5'd6,
                aluSll = 5'd7,
                aluSrl = 5'd8
        } aluOpT;

        // Shared by MemRead and MemWrite
        typedef enum logic [1:0] {
                memNone = 2'd0,
                memWord = 2'd1,
                memHalf = 2'd2,
                memByte = 2'd3
        } memSizeT;

endpackage

`default_nettype wire

//--- design/decodeStage.sv
`timescale 1ns/1ns
`default_nettype none

module decodeStage #(
        parameter int DataWidth    = decodePkg::DataWidth,
        parameter int RegAddrWidth = decodePkg::RegAddrWidth
) (
        input  wire                     Clk,
        input  wire                     rst,
        input  wire [DataWidth-1:0]     Instr,
        input  wire [DataWidth-1:0]     PcPlus4,
        input  wire                     Stall,
        input  wire                     WbWrite,
        input  wire [RegAddrWidth-1:0]  WbAddr,
        input  wire [DataWidth-1:0]     WbData,
        output logic                    RegWriteOut,
        output logic                    AluSrcOut,
        output logic                    RegDstOut,
        output decodePkg::memSizeT      MemWriteOut,
        output decodePkg::memSizeT      MemReadOut,
        output logic                    MemToRegOut,
        output logic                    JrOut,
        output logic                    JalOut,
        output decodePkg::aluOpT        AluControlOut,
        output logic [DataWidth-1:0]    PcPlus4Out,
        output logic [DataWidth-1:0]    ReadData1Out,
        output logic [DataWidth-1:0]    ReadData2Out,
        output logic [DataWidth-1:0]    ImmOut,
        output logic [RegAddrWidth-1:0] RtOut,
        output logic [RegAddrWidth-1:0] RdOut
);

        ctrlIf #(.DataWidth(DataWidth)) ctrl ();
        operandIf #(.DataWidth(DataWidth), .RegAddrWidth(RegAddrWidth)) ops ();

        // Source register number, decoder to register file
        logic [RegAddrWidth-1:0] rs;

        controlDecoder #(.DataWidth(DataWidth), .RegAddrWidth(RegAddrWidth)) decoder (
                .Instr (Instr),
                .Ctrl  (ctrl),
                .Rs    (rs)
        );

        registerFile #(.DataWidth(DataWidth), .RegAddrWidth(RegAddrWidth)) regFile (
                .Clk     (Clk),
                .rst     (rst),
                .Instr   (Instr),
                .Rs      (rs),
                .WbWrite (WbWrite),
                .WbAddr  (WbAddr),
                .WbData  (WbData),
                .Ops     (ops)
        );

        decodeToExecute #(.DataWidth(DataWidth), .RegAddrWidth(RegAddrWidth)) pipeReg (
                .Clk           (Clk),
                .rst           (rst),
                .Stall         (Stall),
                .Ctrl          (ctrl),
                .Ops           (ops),
                .PcPlus4       (PcPlus4),
                .RegWriteOut   (RegWriteOut),
                .AluSrcOut     (AluSrcOut),
                .RegDstOut     (RegDstOut),
                .MemWriteOut   (MemWriteOut),
                .MemReadOut    (MemReadOut),
                .MemToRegOut   (MemToRegOut),
                .JrOut         (JrOut),
                .JalOut        (JalOut),
                .AluControlOut (AluControlOut),
                .PcPlus4Out    (PcPlus4Out),
                .ReadData1Out  (ReadData1Out),
                .ReadData2Out  (ReadData2Out),
                .ImmOut        (ImmOut),
                .RtOut         (RtOut),
                .RdOut         (RdOut)
        );

endmodule

`default_nettype wire

//--- design/decodeToExecute.sv
`timescale 1ns/1ns
`default_nettype none

module decodeToExecute #(
        parameter int DataWidth    = decodePkg::DataWidth,
        parameter int RegAddrWidth = decodePkg::RegAddrWidth
) (
        input  wire                     Clk,
        input  wire                     rst,
        input  wire                     Stall,
        ctrlIf.dst                      Ctrl,
        operandIf.dst                   Ops,
        input  wire [DataWidth-1:0]     PcPlus4,
        output logic                    RegWriteOut,
        output logic                    AluSrcOut,
        output logic                    RegDstOut,
        output decodePkg::memSizeT      MemWriteOut,
        output decodePkg::memSizeT      MemReadOut,
        output logic                    MemToRegOut,
        output logic                    JrOut,
        output logic                    JalOut,
        output decodePkg::aluOpT        AluControlOut,
        output logic [DataWidth-1:0]    PcPlus4Out,
        output logic [DataWidth-1:0]    ReadData1Out,
        output logic [DataWidth-1:0]    ReadData2Out,
        output logic [DataWidth-1:0]    ImmOut,
        output logic [RegAddrWidth-1:0] RtOut,
        output logic [RegAddrWidth-1:0] RdOut
);

        ////////////////////
        // Control fields
        ////////////////////

        // Reset wins over Stall and leaves a bubble behind
        always_ff @(posedge Clk) begin
                if (rst) begin
                        RegWriteOut   <= 1'b0;
                        MemWriteOut   <= decodePkg::memNone;
                        MemReadOut    <= decodePkg::memNone;
                        MemToRegOut   <= 1'b0;
                        JrOut         <= 1'b0;
                        JalOut        <= 1'b0;
                        AluControlOut <= decodePkg::aluNop;
                end else if (!Stall) begin
                        RegWriteOut   <= Ctrl.RegWrite;
                        MemWriteOut   <= Ctrl.MemWrite;
                        MemReadOut    <= Ctrl.MemRead;
                        MemToRegOut   <= Ctrl.MemToReg;
                        JrOut         <= Ctrl.Jr;
                        JalOut        <= Ctrl.Jal;
                        AluControlOut <= Ctrl.AluControl;
                end
        end

        ////////////////////
        // Operand and mux-select fields
        ////////////////////

        // Harmless while the controls above read as a bubble
        always_ff @(posedge Clk) begin
                if (!Stall) begin
                        AluSrcOut    <= Ctrl.AluSrc;
                        RegDstOut    <= Ctrl.RegDst;
                        ImmOut       <= Ctrl.Imm;
                        PcPlus4Out   <= PcPlus4;
                        ReadData1Out <= Ops.ReadData1;
                        ReadData2Out <= Ops.ReadData2;
                        RtOut        <= Ops.Rt;
                        RdOut        <= Ops.Rd;
                end
        end

endmodule

`default_nettype wire

//--- design/registerFile.sv
`timescale 1ns/1ns
`default_nettype none

module registerFile #(
        parameter int DataWidth    = decodePkg::DataWidth,
        parameter int RegAddrWidth = decodePkg::RegAddrWidth
) (
        input  wire                    Clk,
        input  wire                    rst,
        input  wire [DataWidth-1:0]    Instr,
        input  wire [RegAddrWidth-1:0] Rs,
        input  wire                    WbWrite,
        input  wire [RegAddrWidth-1:0] WbAddr,
        input  wire [DataWidth-1:0]    WbData,
        operandIf.src                  Ops
);

        localparam int Depth = 2 ** RegAddrWidth;

        logic [DataWidth-1:0]    regs [Depth];
        logic [RegAddrWidth-1:0] rt;
        logic                    wbValid;

        assign rt = Instr[20:16];

        // Writes to register 0 are dropped
        assign wbValid = WbWrite && (WbAddr != '0);

        always_ff @(posedge Clk) begin
                if (rst) begin
                        for (int i = 0; i < Depth; i++) begin
                                regs[i] <= '0;
                        end
                end else if (wbValid) begin
                        regs[WbAddr] <= WbData;
                end
        end

        ////////////////////
        // Read ports with same-cycle bypass
        ////////////////////

        assign Ops.ReadData1 = (Rs == '0) ? '0 :
                               (wbValid && WbAddr == Rs) ? WbData : regs[Rs];

        assign Ops.ReadData2 = (rt == '0) ? '0 :
                               (wbValid && WbAddr == rt) ? WbData : regs[rt];

        // Destination candidates travel with the operands
        assign Ops.Rt = rt;
        assign Ops.Rd = Instr[15:11];

endmodule

`default_nettype wire

//--- run.sh
#!/bin/sh
# Build with Verilator, run, and look for the pass line in the output
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f compile.f --top-module decodeStageTb -Mdir obj_dir \
        && ./obj_dir/VdecodeStageTb | tee /dev/stderr | grep -q "Simulation finished: PASS" \
        && echo "run.sh: passed" && exit 0 \
        || { echo "run.sh: failed"; exit 1; }

//--- verif/clockGen.sv
`timescale 1ns/1ns
`default_nettype none

module clockGen #(
        parameter int PeriodNs    = 8,
        parameter int ResetCycles = 10
) (
        output logic Clk,
        output logic rst
);

        initial begin
                Clk = 1'b0;
                forever #(PeriodNs / 2) Clk = ~Clk;
        end

        // Released on a falling edge, in step with the stimulus
        initial begin
                rst = 1'b1;
                repeat (ResetCycles) @(posedge Clk);
                @(negedge Clk);
                rst = 1'b0;
        end

endmodule

`default_nettype wire

//--- verif/decodeStageMon.sv
`timescale 1ns/1ns
`default_nettype none

module decodeStageMon (
        input wire        Clk,
        input wire        rst,
        input wire        Stall,
        input wire [31:0] Instr, PcPlus4,
        input wire        WbWrite,
        input wire [4:0]  WbAddr,
        input wire [31:0] WbData,
        input wire        RegWriteOut, AluSrcOut, RegDstOut, MemToRegOut, JrOut, JalOut,
        input wire [1:0]  MemWriteOut, MemReadOut,
        input wire [4:0]  AluControlOut, RtOut, RdOut,
        input wire [31:0] PcPlus4Out, ReadData1Out, ReadData2Out, ImmOut,
        output int        ErrCount,
        output int        CheckCount
);

        typedef struct packed {
                logic        regWrite;
                logic        aluSrc;
                logic        regDst;
                logic        memToReg;
                logic        jr;
                logic        jal;
                logic [1:0]  memWrite;
                logic [1:0]  memRead;
                logic [4:0]  aluCtl;
                logic        immUsed;
                logic [31:0] imm;
        } ctrlT;

        logic [31:0] shadow [32];
        ctrlT        expCtrl;
        logic [31:0] expPc;
        logic [31:0] expRd1;
        logic [31:0] expRd2;
        logic [4:0]  expRt;
        logic [4:0]  expRd;
        logic        ctrlKnown = 1'b0;
        logic        dataKnown = 1'b0;
        int          errors = 0;
        int          checks = 0;

        assign ErrCount   = errors;
        assign CheckCount = checks;

        ////////////////////
        // Reference decode
        ////////////////////

        // Flags are {RegWrite, AluSrc, RegDst, MemToReg, Jr, Jal}
        function automatic ctrlT makeCtrl(input logic [5:0] flags, input logic [1:0] memW,
                                          input logic [1:0] memR, input logic [4:0] alu);
                ctrlT r;
                r = '0;
                {r.regWrite, r.aluSrc, r.regDst, r.memToReg, r.jr, r.jal} = flags;
                r.memWrite = memW;
                r.memRead  = memR;
                r.aluCtl   = alu;
                return r;
        endfunction

        function automatic ctrlT refFunct(input logic [5:0] fn, input logic [4:0] shamt);
                ctrlT r;
                case (fn)
                        6'h20: r = makeCtrl(6'b101000, 2'd0, 2'd0, decodePkg::aluAdd);
                        6'h22: r = makeCtrl(6'b101000, 2'd0, 2'd0, decodePkg::aluSub);
                        6'h24: r = makeCtrl(6'b101000, 2'd0, 2'd0, decodePkg::aluAnd);
                        6'h25: r = makeCtrl(6'b101000, 2'd0, 2'd0, decodePkg::aluOr);
                        6'h27: r = makeCtrl(6'b101000, 2'd0, 2'd0, decodePkg::aluNor);
                        6'h2a: r = makeCtrl(6'b101000, 2'd0, 2'd0, decodePkg::aluSlt);
                        6'h00: r = makeCtrl(6'b101000, 2'd0, 2'd0, decodePkg::aluSll);
                        6'h02: r = makeCtrl(6'b101000, 2'd0, 2'd0, decodePkg::aluSrl);
                        6'h08: r = makeCtrl(6'b000010, 2'd0, 2'd0, decodePkg::aluNop);
                        default: r = '0;
                endcase
                // Shifts carry shamt in the immediate
                if (fn == 6'h00 || fn == 6'h02) begin
                        r.immUsed = 1'b1;
                        r.imm     = {27'd0, shamt};
                end
                return r;
        endfunction

        // Memory sizes: 1 word, 2 half, 3 byte
        function automatic ctrlT refDecode(input logic [31:0] ins);
                ctrlT r;
                case (ins[31:26])
                        6'h00: r = refFunct(ins[5:0], ins[10:6]);
                        6'h08: r = makeCtrl(6'b110000, 2'd0, 2'd0, decodePkg::aluAdd);
                        6'h0a: r = makeCtrl(6'b110000, 2'd0, 2'd0, decodePkg::aluSlt);
                        6'h0c: r = makeCtrl(6'b110000, 2'd0, 2'd0, decodePkg::aluAnd);
                        6'h0d: r = makeCtrl(6'b110000, 2'd0, 2'd0, decodePkg::aluOr);
                        6'h23: r = makeCtrl(6'b110100, 2'd0, 2'd1, decodePkg::aluAdd);
                        6'h21: r = makeCtrl(6'b110100, 2'd0, 2'd2, decodePkg::aluAdd);
                        6'h20: r = makeCtrl(6'b110100, 2'd0, 2'd3, decodePkg::aluAdd);
                        6'h2b: r = makeCtrl(6'b010000, 2'd1, 2'd0, decodePkg::aluAdd);
                        6'h29: r = makeCtrl(6'b010000, 2'd2, 2'd0, decodePkg::aluAdd);
                        6'h28: r = makeCtrl(6'b010000, 2'd3, 2'd0, decodePkg::aluAdd);
                        6'h03: r = makeCtrl(6'b100001, 2'd0, 2'd0, decodePkg::aluNop);
                        default: r = '0;
                endcase
                // andi and ori zero-extend, the other immediate forms sign-extend
                if (r.aluSrc) begin
                        r.immUsed = 1'b1;
                        if (ins[31:26] == 6'h0c || ins[31:26] == 6'h0d) begin
                                r.imm = {16'd0, ins[15:0]};
                        end else begin
                                r.imm = {{16{ins[15]}}, ins[15:0]};
                        end
                end
                return r;
        endfunction

        // Register 0 reads zero, a same-cycle write is seen at once
        function automatic logic [31:0] readReg(input logic [4:0] a);
                if (a == 5'd0) begin
                        return 32'd0;
                end
                if (WbWrite && WbAddr == a) begin
                        return WbData;
                end
                return shadow[a];
        endfunction

        task automatic compare(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
                if (got !== exp) begin
                        errors++;
                        $display("ERR %0t: %s is %h, expected %h", $time, name, got, exp);
                end
        endtask

        ////////////////////
        // Expected state
        ////////////////////

        always @(posedge Clk) begin
                if (rst) begin
                        expCtrl   <= '0;
                        ctrlKnown <= 1'b1;
                        dataKnown <= 1'b0;
                        for (int i = 0; i < 32; i++) begin
                                shadow[i] <= '0;
                        end
                end else begin
                        if (!Stall) begin
                                expCtrl   <= refDecode(Instr);
                                expPc     <= PcPlus4;
                                expRd1    <= readReg(Instr[25:21]);
                                expRd2    <= readReg(Instr[20:16]);
                                expRt     <= Instr[20:16];
                                expRd     <= Instr[15:11];
                                dataKnown <= 1'b1;
                        end
                        if (WbWrite && WbAddr != 5'd0) begin
                                shadow[WbAddr] <= WbData;
                        end
                end
        end

        // Outputs settle at the rising edge, so the falling edge is safe
        always @(negedge Clk) begin
                if (ctrlKnown) begin
                        checks++;
                        compare("RegWriteOut", 32'(RegWriteOut), 32'(expCtrl.regWrite));
                        compare("MemWriteOut", 32'(MemWriteOut), 32'(expCtrl.memWrite));
                        compare("MemReadOut", 32'(MemReadOut), 32'(expCtrl.memRead));
                        compare("MemToRegOut", 32'(MemToRegOut), 32'(expCtrl.memToReg));
                        compare("JrOut", 32'(JrOut), 32'(expCtrl.jr));
                        compare("JalOut", 32'(JalOut), 32'(expCtrl.jal));
                        compare("AluControlOut", 32'(AluControlOut), 32'(expCtrl.aluCtl));
                end
                if (dataKnown) begin
                        compare("AluSrcOut", 32'(AluSrcOut), 32'(expCtrl.aluSrc));
                        compare("RegDstOut", 32'(RegDstOut), 32'(expCtrl.regDst));
                        compare("PcPlus4Out", PcPlus4Out, expPc);
                        compare("ReadData1Out", ReadData1Out, expRd1);
                        compare("ReadData2Out", ReadData2Out, expRd2);
                        compare("RtOut", 32'(RtOut), 32'(expRt));
                        compare("RdOut", 32'(RdOut), 32'(expRd));
                        if (expCtrl.immUsed) begin
                                compare("ImmOut", ImmOut, expCtrl.imm);
                        end
                end
        end

endmodule

`default_nettype wire

//--- verif/decodeStageTb.sv
`timescale 1ns/1ns
`default_nettype none

module decodeStageTb;

        localparam int PeriodNs  = 8;
        localparam int NumCycles = 3000;
        localparam int Seed      = 19714;

        logic                Clk;
        logic                rst;
        logic [31:0]         Instr;
        logic [31:0]         PcPlus4;
        logic                Stall;
        logic                WbWrite;
        logic [4:0]          WbAddr;
        logic [31:0]         WbData;
        logic                RegWriteOut, AluSrcOut, RegDstOut, MemToRegOut, JrOut, JalOut;
        decodePkg::memSizeT  MemWriteOut;
        decodePkg::memSizeT  MemReadOut;
        decodePkg::aluOpT    AluControlOut;
        logic [31:0]         PcPlus4Out, ReadData1Out, ReadData2Out, ImmOut;
        logic [4:0]          RtOut, RdOut;
        int                  errCount;
        int                  checkCount;
        int                  totalErrors;

        // Primary opcodes of the subset, special first
        logic [5:0] legalOps [12] = '{6'h00, 6'h03, 6'h08, 6'h0a, 6'h0c, 6'h0d,
                                      6'h20, 6'h21, 6'h23, 6'h28, 6'h29, 6'h2b};
        logic [5:0] legalFuncts [9] = '{6'h00, 6'h02, 6'h08, 6'h20, 6'h22, 6'h24,
                                        6'h25, 6'h27, 6'h2a};

        clockGen #(.PeriodNs(PeriodNs), .ResetCycles(10)) clkGen (.Clk(Clk), .rst(rst));

        decodeStage dut (.*);

        decodeStageMon mon (.*, .ErrCount(errCount), .CheckCount(checkCount));

        bind decodeStage decodeStageChk chk (.*);

        function automatic logic [31:0] randomInstr();
                logic [31:0] ins;
                logic [3:0]  pick;
                ins        = $urandom();
                pick       = 4'($urandom_range(11));
                ins[31:26] = legalOps[pick];
                if (ins[31:26] == 6'h00) begin
                        ins[5:0] = legalFuncts[4'($urandom_range(8))];
                end
                // About one in ten falls outside the subset
                if ($urandom_range(9) == 0) begin
                        if ($urandom_range(1) == 0) begin
                                ins[31:26] = 6'h04;
                        end else begin
                                ins[31:26] = 6'h00;
                                ins[5:0]   = 6'h3f;
                        end
                end
                return ins;
        endfunction

        initial begin
                void'($urandom(Seed));
                Instr   = '0;
                PcPlus4 = '0;
                Stall   = 1'b0;
                WbWrite = 1'b0;
                WbAddr  = '0;
                WbData  = '0;
                wait (rst == 1'b0);
                repeat (NumCycles) begin
                        @(negedge Clk);
                        Instr   = randomInstr();
                        PcPlus4 = PcPlus4 + 32'd4;
                        Stall   = $urandom_range(99) < 20;
                        WbWrite = 1'($urandom_range(1));
                        // Aim some writes at rs to exercise the bypass
                        WbAddr  = ($urandom_range(3) == 0) ? Instr[25:21] : 5'($urandom());
                        WbData  = $urandom();
                end
                repeat (2) @(posedge Clk);
                totalErrors = errCount + dut.chk.failures;
                $display("Checks: %0d, errors: %0d", checkCount, totalErrors);
                if (totalErrors == 0 && checkCount > 0) begin
                        $display("Simulation finished: PASS");
                end else begin
                        $display("Simulation finished: FAIL");
                end
                $finish;
        end

        // Watchdog
        initial begin
                #(2 * NumCycles * PeriodNs);
                $display("Timeout: stimulus did not finish within %0d ns",
                         2 * NumCycles * PeriodNs);
                $display("Simulation finished: FAIL");
                $finish;
        end

endmodule

`default_nettype wire

//--- verif/decodeStage_chk.sv
`timescale 1ns/1ns
`default_nettype none

module decodeStageChk (
        input wire        Clk,
        input wire        rst,
        input wire        Stall,
        input wire        RegWriteOut, AluSrcOut, RegDstOut, MemToRegOut, JrOut, JalOut,
        input wire [1:0]  MemWriteOut, MemReadOut,
        input wire [4:0]  AluControlOut, RtOut, RdOut,
        input wire [31:0] PcPlus4Out, ReadData1Out, ReadData2Out, ImmOut
);

        // Assertion failures so far
        int failures = 0;

        // A reset edge leaves a bubble behind
        assert property (@(posedge Clk) rst |=> (!RegWriteOut && !MemToRegOut && !JrOut
                         && !JalOut && MemWriteOut == 2'd0 && MemReadOut == 2'd0
                         && AluControlOut == 5'd0))
                else begin
                        failures++;
                        $error("control outputs not cleared after reset");
                end

        assert property (@(posedge Clk) disable iff (rst) Stall |=> $stable({RegWriteOut,
                         AluSrcOut, RegDstOut, MemToRegOut, JrOut, JalOut, MemWriteOut,
                         MemReadOut, AluControlOut, RtOut, RdOut, PcPlus4Out, ReadData1Out,
                         ReadData2Out, ImmOut}))
                else begin
                        failures++;
                        $error("outputs changed during a stalled cycle");
                end

        assert property (@(posedge Clk) disable iff (rst) !(JrOut && JalOut))
                else begin
                        failures++;
                        $error("JrOut and JalOut high together");
                end

endmodule

`default_nettype wire
